//--- design/vdp_params.svh
/*
  Sizing and constants for the host side of the VDP.
  The raster numbers assume a 525-line frame scanned at double rate on cy.
*/
`ifndef VDP_PARAMS_SVH
`define VDP_PARAMS_SVH

// Bus widths
`define VDP_DATA_W       8
`define VDP_VRAM_AW      17
`define VDP_LOW_AW       14

// Dot-state cycle and the phase granted to the CPU
`define VDP_SLOT_PHASES  4
`define VDP_CPU_SLOT     1

// Register indices still implemented
`define VDP_REG_R0       0
`define VDP_REG_R1       1
`define VDP_REG_R14      14
`define VDP_REG_R15      15
`define VDP_REG_R19      19

// Vertical blank starts on this cy value
`define VDP_VBLANK_CY    424

// Identification field of S#1 (V9958)
`define VDP_CHIP_ID      2

`endif

//--- design/vdp_pkg.sv
/*
  Types passed between the port decoder, the access executor and the
  status stage. Widths come from vdp_params.svh.
*/
`default_nettype none

package vdp_pkg;

`include "vdp_params.svh"

  // ------------------------------------------------------------
  // Basic data types
  // ------------------------------------------------------------
  typedef logic [`VDP_DATA_W-1:0]  data_t;
  typedef logic [`VDP_VRAM_AW-1:0] vram_addr_t;

  // Operations decoded from host port accesses
  typedef enum logic [2:0] {
    OP_NONE,
    OP_VRAM_WR,
    OP_VRAM_RD,
    OP_ADDR_SET,
    OP_REG_WR,
    OP_STATUS_RD
  } vdp_op_e;

  // One-cycle operation strobe from the decoder
  typedef struct packed {
    logic                   valid;
    vdp_op_e                op;
    logic [5:0]             reg_num;
    data_t                  data;
    logic [`VDP_LOW_AW-1:0] addr_lo;
  } port_op_t;

  // Register bits that the status stage needs
  typedef struct packed {
    logic       hsync_int_en;
    logic       vsync_int_en;
    logic [3:0] status_sel;
    logic [7:0] int_line;
  } ctrl_regs_t;

  // Completion of an executed operation
  typedef struct packed {
    logic  done;
    logic  is_read;
    data_t rd_data;
  } exec_done_t;

  // ------------------------------------------------------------
  // FSM states
  // ------------------------------------------------------------
  typedef enum logic {
    LATCH_EMPTY,
    LATCH_FULL
  } decode_state_e;

  typedef enum logic {
    EXEC_IDLE,
    EXEC_WAIT_SLOT
  } exec_state_e;

endpackage

`default_nettype wire

//--- design/vdp_port_decode.sv
/*
  Host port decoder. reset is the clock, clk21m the async active-high reset.
  Modes 2 and 3 are ignored. The host waits for ack before the next req.
*/
`timescale 1ns/10ps
`default_nettype none

module vdp_port_decode (
  input  wire                   reset,
  input  wire                   clk21m,
  input  wire                   req,
  input  wire                   wrt,
  input  wire  [1:0]            mode,
  input  wire  vdp_pkg::data_t  dbo,
  output vdp_pkg::port_op_t     op,
  output logic                  latch_ack
);

  vdp_pkg::decode_state_e state;
  vdp_pkg::data_t         latch_q;
  logic                   data_acc;
  logic                   stat_rd;
  logic                   ctrl_wr;

  // Port classification
  assign data_acc = req && (mode == 2'd0);
  assign stat_rd  = req && (mode == 2'd1) && !wrt;
  assign ctrl_wr  = req && (mode == 2'd1) && wrt;

  // ------------------------------------------------------------
  // Control latch FSM and op strobe
  // ------------------------------------------------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      state     <= vdp_pkg::LATCH_EMPTY;
      op        <= '0;
      latch_ack <= 1'b0;
    end else begin
      op        <= '0;
      latch_ack <= 1'b0;
      if (data_acc) begin
        state    <= vdp_pkg::LATCH_EMPTY;
        op.valid <= 1'b1;
        op.op    <= wrt ? vdp_pkg::OP_VRAM_WR : vdp_pkg::OP_VRAM_RD;
        op.data  <= dbo;
      end else if (stat_rd) begin
        state    <= vdp_pkg::LATCH_EMPTY;
        op.valid <= 1'b1;
        op.op    <= vdp_pkg::OP_STATUS_RD;
      end else if (ctrl_wr) begin
        if (state == vdp_pkg::LATCH_EMPTY) begin
          // First byte only fills the latch
          state     <= vdp_pkg::LATCH_FULL;
          latch_ack <= 1'b1;
        end else begin
          state      <= vdp_pkg::LATCH_EMPTY;
          op.valid   <= 1'b1;
          op.reg_num <= dbo[5:0];
          op.data    <= latch_q;
          op.addr_lo <= {dbo[5:0], latch_q};
          // Bit 7 picks register write over address setup
          op.op      <= dbo[7] ? vdp_pkg::OP_REG_WR : vdp_pkg::OP_ADDR_SET;
        end
      end
    end
  end

  // First control byte
  always_ff @(posedge reset) begin
    if (ctrl_wr && (state == vdp_pkg::LATCH_EMPTY)) begin
      latch_q <= dbo;
    end
  end

endmodule

`default_nettype wire

//--- design/vdp_access_exec.sv
/*
  Control registers, VRAM address counter and CPU-slot VRAM access.
  A VRAM op waits for the CPU phase, so it completes within 4 cycles.
*/
`timescale 1ns/10ps
`default_nettype none

`include "vdp_params.svh"

module vdp_access_exec (
  input  wire                      reset,
  input  wire                      clk21m,
  input  wire  vdp_pkg::port_op_t  op,
  input  wire  [15:0]              pram_dbi,
  output vdp_pkg::ctrl_regs_t      regs,
  output vdp_pkg::exec_done_t      done,
  output vdp_pkg::vram_addr_t      pram_adr,
  output logic                     pram_we_n,
  output vdp_pkg::data_t           pram_dbo
);

  localparam int unsigned SLOT_W = $clog2(`VDP_SLOT_PHASES);

  vdp_pkg::exec_state_e                state;
  logic [SLOT_W-1:0]                   slot;
  vdp_pkg::vram_addr_t                 vaddr;
  vdp_pkg::vram_addr_t                 vaddr_next;
  logic [`VDP_VRAM_AW-`VDP_LOW_AW-1:0] r14;
  logic                                pend_wr;
  vdp_pkg::data_t                      wr_data;
  vdp_pkg::data_t                      rd_data_q;
  vdp_pkg::data_t                      lane_byte;
  logic                                done_q;
  logic                                is_read_q;
  logic                                exec_op;
  logic                                grant;

  assign exec_op    = op.valid && (op.op != vdp_pkg::OP_STATUS_RD);
  assign grant      = (state == vdp_pkg::EXEC_WAIT_SLOT) &&
                      (slot == SLOT_W'(`VDP_CPU_SLOT));
  assign vaddr_next = vaddr + 1'b1;

  // Byte lane picked by address bit 0
  assign lane_byte = vaddr[0] ? pram_dbi[15:8] : pram_dbi[7:0];

  assign pram_adr  = vaddr;
  assign pram_we_n = ~(grant & pend_wr);
  assign pram_dbo  = wr_data;
  assign done      = '{done: done_q, is_read: is_read_q, rd_data: rd_data_q};

  // Dot-state counter
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      slot <= '0;
    end else if (slot == SLOT_W'(`VDP_SLOT_PHASES - 1)) begin
      slot <= '0;
    end else begin
      slot <= slot + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Executor FSM
  // ------------------------------------------------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      state     <= vdp_pkg::EXEC_IDLE;
      vaddr     <= '0;
      r14       <= '0;
      pend_wr   <= 1'b0;
      regs      <= '0;
      done_q    <= 1'b0;
      is_read_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        vdp_pkg::EXEC_IDLE: begin
          if (exec_op) begin
            case (op.op)
              vdp_pkg::OP_VRAM_WR, vdp_pkg::OP_VRAM_RD: begin
                state   <= vdp_pkg::EXEC_WAIT_SLOT;
                pend_wr <= (op.op == vdp_pkg::OP_VRAM_WR);
              end
              vdp_pkg::OP_ADDR_SET: begin
                // High bits come from R14
                vaddr     <= {r14, op.addr_lo};
                done_q    <= 1'b1;
                is_read_q <= 1'b0;
              end
              vdp_pkg::OP_REG_WR: begin
                case (op.reg_num)
                  6'(`VDP_REG_R0):  regs.hsync_int_en <= op.data[4];
                  6'(`VDP_REG_R1):  regs.vsync_int_en <= op.data[5];
                  6'(`VDP_REG_R14): r14 <= op.data[2:0];
                  6'(`VDP_REG_R15): regs.status_sel <= op.data[3:0];
                  6'(`VDP_REG_R19): regs.int_line <= op.data;
                  default: ;
                endcase
                done_q    <= 1'b1;
                is_read_q <= 1'b0;
              end
              default: ;
            endcase
          end
        end
        vdp_pkg::EXEC_WAIT_SLOT: begin
          if (grant) begin
            vaddr <= vaddr_next;
            // Carry out of the low bits moves R14 along
            if (&vaddr[`VDP_LOW_AW-1:0]) begin
              r14 <= vaddr_next[`VDP_VRAM_AW-1:`VDP_LOW_AW];
            end
            done_q    <= 1'b1;
            is_read_q <= ~pend_wr;
            state     <= vdp_pkg::EXEC_IDLE;
          end
        end
        default: state <= vdp_pkg::EXEC_IDLE;
      endcase
    end
  end

  // Write byte and read capture
  always_ff @(posedge reset) begin
    if (exec_op && (op.op == vdp_pkg::OP_VRAM_WR)) begin
      wr_data <= op.data;
    end
    if (grant) begin
      rd_data_q <= lane_byte;
    end
  end

endmodule

`default_nettype wire

//--- design/vdp_status_result.sv
/*
  Interrupt flags, int_n, S#0/S#1 read-back and the host ack/dbi.
  Flags set once on entry to a matching raster position.
*/
`timescale 1ns/10ps
`default_nettype none

`include "vdp_params.svh"

module vdp_status_result (
  input  wire                        reset,
  input  wire                        clk21m,
  input  wire  vdp_pkg::port_op_t    op,
  input  wire                        latch_ack,
  input  wire  vdp_pkg::exec_done_t  done,
  input  wire  vdp_pkg::ctrl_regs_t  regs,
  input  wire  [10:0]                cx,
  input  wire  [9:0]                 cy,
  output logic                       ack,
  output vdp_pkg::data_t             dbi,
  output logic                       int_n
);

  logic           vb_match;
  logic           ln_match;
  logic           vb_match_q;
  logic           ln_match_q;
  logic           f_flag;
  logic           fh_flag;
  logic           stat_rd;
  vdp_pkg::data_t status_byte;

  // Raster matches
  assign vb_match = (cx == '0) && (cy == 10'(`VDP_VBLANK_CY));
  assign ln_match = (cx == '0) && (cy[8:1] == regs.int_line);

  assign stat_rd = op.valid && (op.op == vdp_pkg::OP_STATUS_RD);

  // Status register mux
  always_comb begin
    case (regs.status_sel)
      4'd0:    status_byte = {f_flag, 7'd0};
      4'd1:    status_byte = {2'b00, 5'(`VDP_CHIP_ID), fh_flag};
      default: status_byte = '0;
    endcase
  end

  assign int_n = ~((f_flag & regs.vsync_int_en) | (fh_flag & regs.hsync_int_en));

  // ------------------------------------------------------------
  // Flags and ack
  // ------------------------------------------------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      vb_match_q <= 1'b0;
      ln_match_q <= 1'b0;
      f_flag     <= 1'b0;
      fh_flag    <= 1'b0;
      ack        <= 1'b0;
    end else begin
      vb_match_q <= vb_match;
      ln_match_q <= ln_match;
      ack        <= latch_ack | done.done | stat_rd;

      // New match wins over a read in the same cycle
      if (vb_match && !vb_match_q) begin
        f_flag <= 1'b1;
      end else if (stat_rd && (regs.status_sel == 4'd0)) begin
        f_flag <= 1'b0;
      end

      if (ln_match && !ln_match_q) begin
        fh_flag <= 1'b1;
      end else if (stat_rd && (regs.status_sel == 4'd1)) begin
        fh_flag <= 1'b0;
      end
    end
  end

  // Read data, valid in the ack cycle
  always_ff @(posedge reset) begin
    if (stat_rd) begin
      dbi <= status_byte;
    end else if (done.done && done.is_read) begin
      dbi <= done.rd_data;
    end
  end

endmodule

`default_nettype wire

//--- design/vdp_core.sv
/*
  Host side of the VDP. reset is the clock, clk21m the async active-high reset.
  Raster position arrives on cx/cy. VRAM reads go out on demand.
*/
`timescale 1ns/10ps
`default_nettype none

module vdp_core (
  input  wire                    reset,
  input  wire                    clk21m,
  input  wire                    req,
  input  wire                    wrt,
  input  wire  [1:0]             mode,
  input  wire  vdp_pkg::data_t   dbo,
  input  wire  [15:0]            pram_dbi,
  input  wire  [10:0]            cx,
  input  wire  [9:0]             cy,
  output wire                    ack,
  output vdp_pkg::data_t         dbi,
  output wire                    int_n,
  output vdp_pkg::vram_addr_t    pram_adr,
  output wire                    pram_we_n,
  output vdp_pkg::data_t         pram_dbo
);

  vdp_pkg::port_op_t   port_op;
  vdp_pkg::ctrl_regs_t ctrl_regs;
  vdp_pkg::exec_done_t exec_done;
  wire                 latch_ack;

  // Host port decode
  vdp_port_decode port_decode_i (
    .reset     (reset),
    .clk21m    (clk21m),
    .req       (req),
    .wrt       (wrt),
    .mode      (mode),
    .dbo       (dbo),
    .op        (port_op),
    .latch_ack (latch_ack)
  );

  // Registers and VRAM access
  vdp_access_exec access_exec_i (
    .reset     (reset),
    .clk21m    (clk21m),
    .op        (port_op),
    .pram_dbi  (pram_dbi),
    .regs      (ctrl_regs),
    .done      (exec_done),
    .pram_adr  (pram_adr),
    .pram_we_n (pram_we_n),
    .pram_dbo  (pram_dbo)
  );

  // Interrupts, status and ack
  vdp_status_result status_result_i (
    .reset     (reset),
    .clk21m    (clk21m),
    .op        (port_op),
    .latch_ack (latch_ack),
    .done      (exec_done),
    .regs      (ctrl_regs),
    .cx        (cx),
    .cy        (cy),
    .ack       (ack),
    .dbi       (dbi),
    .int_n     (int_n)
  );

endmodule

`default_nettype wire

//--- tb/vdp_core_checker.sv
/*
  Host bus protocol assertions, bound into every vdp_core instance.
  reset is the clock and clk21m the active-high reset.
*/
`timescale 1ns/10ps
`default_nettype none

module vdp_core_checker (
  input wire reset,
  input wire clk21m,
  input wire ack,
  input wire pram_we_n,
  input wire int_n
);

  int fail_count = 0;

  // Ack is a single-cycle pulse
  ack_single: assert property (@(posedge reset) disable iff (clk21m) ack |=> !ack)
    else begin
      $error("ack high in two consecutive cycles");
      fail_count++;
    end

  // One write strobe cycle per access
  we_single: assert property (@(posedge reset) disable iff (clk21m) !pram_we_n |=> pram_we_n)
    else begin
      $error("pram_we_n low in two consecutive cycles");
      fail_count++;
    end

  int_idle_in_reset: assert property (@(posedge reset) clk21m |-> int_n)
    else begin
      $error("int_n low while clk21m is high");
      fail_count++;
    end

endmodule

bind vdp_core vdp_core_checker checker_i (
  .reset     (reset),
  .clk21m    (clk21m),
  .ack       (ack),
  .pram_we_n (pram_we_n),
  .int_n     (int_n)
);

`default_nettype wire

//--- tb/vdp_core_tb.sv
/*
  Testbench for vdp_core, driven by tb/vdp_core_vectors.txt from the project root.
  Stops at the first mismatch or at a missing ack.
*/
`timescale 1ns/10ps
`default_nettype none

module vdp_core_tb;

  localparam int TIMEOUT_CYCLES = 64;
  localparam int VRAM_SIZE      = 1 << $bits(vdp_pkg::vram_addr_t);

  logic                reset;
  logic                clk21m;
  logic                req;
  logic                wrt;
  logic [1:0]          mode;
  vdp_pkg::data_t      dbo;
  wire  [15:0]         pram_dbi;
  logic [10:0]         cx;
  logic [9:0]          cy;
  wire                 ack;
  vdp_pkg::data_t      dbi;
  wire                 int_n;
  vdp_pkg::vram_addr_t pram_adr;
  wire                 pram_we_n;
  vdp_pkg::data_t      pram_dbo;

  // VRAM model, one byte per address
  vdp_pkg::data_t vram [0:VRAM_SIZE-1];

  vdp_core vdp_core_i (
    .reset     (reset),
    .clk21m    (clk21m),
    .req       (req),
    .wrt       (wrt),
    .mode      (mode),
    .dbo       (dbo),
    .pram_dbi  (pram_dbi),
    .cx        (cx),
    .cy        (cy),
    .ack       (ack),
    .dbi       (dbi),
    .int_n     (int_n),
    .pram_adr  (pram_adr),
    .pram_we_n (pram_we_n),
    .pram_dbo  (pram_dbo)
  );

  initial begin
    reset = 1'b0;
    forever #4 reset = ~reset;
  end

  // Both lanes of the 16-bit word holding pram_adr
  assign pram_dbi = {vram[{pram_adr[16:1], 1'b1}], vram[{pram_adr[16:1], 1'b0}]};

  // Write strobe is stable across the falling edge
  always @(negedge reset) begin
    if (pram_we_n === 1'b0) begin
      vram[pram_adr] = pram_dbo;
    end
  end

  // ------------------------------------------------------------
  // Failure and compare tasks
  // ------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_data(input string name, input vdp_pkg::data_t got,
                            input vdp_pkg::data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s = 0x%02h, expected 0x%02h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input vdp_pkg::vram_addr_t got,
                            input vdp_pkg::vram_addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s = 0x%05h, expected 0x%05h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_int(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // Host bus and interrupt waits
  // ------------------------------------------------------------
  task automatic port_access(input logic write, input logic [1:0] port,
                             input vdp_pkg::data_t wdata, output vdp_pkg::data_t rdata);
    int cycles;
    cycles = 0;
    req    = 1'b1;
    wrt    = write;
    mode   = port;
    dbo    = wdata;
    @(negedge reset);
    req    = 1'b0;
    wrt    = 1'b0;
    while (ack !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(negedge reset);
      cycles++;
    end
    if (ack !== 1'b1) begin
      abort_run($sformatf("No ack for the access on mode %0d within %0d cycles",
                          port, TIMEOUT_CYCLES));
    end
    rdata = dbi;
  endtask

  task automatic wait_int(input logic exp);
    int cycles;
    cycles = 0;
    while (int_n !== exp && cycles < TIMEOUT_CYCLES) begin
      @(negedge reset);
      cycles++;
    end
    if (int_n !== exp) begin
      $display("int_n did not reach %b within %0d cycles", exp, TIMEOUT_CYCLES);
    end
    check_int("int_n", int_n, exp);
  endtask

  // ------------------------------------------------------------
  // Vector interpreter
  // ------------------------------------------------------------
  initial begin
    int             fd;
    int             n;
    string          line;
    byte            cmd;
    logic [31:0]    f1;
    logic [31:0]    f2;
    vdp_pkg::data_t rd;

    clk21m = 1'b1;
    req    = 1'b0;
    wrt    = 1'b0;
    mode   = 2'd0;
    dbo    = '0;
    cx     = 11'd1;
    cy     = 10'd0;
    void'($urandom(32'h8f53));
    for (int i = 0; i < VRAM_SIZE; i++) begin
      vram[i] = vdp_pkg::data_t'($urandom);
    end

    repeat (8) @(posedge reset);
    @(negedge reset);
    clk21m = 1'b0;

    fd = $fopen("tb/vdp_core_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open tb/vdp_core_vectors.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n < 2 || line[0] == "#") begin
        continue;
      end
      f1 = '0;
      f2 = '0;
      n  = $sscanf(line, "%c %h %h", cmd, f1, f2);
      case (cmd)
        "W": port_access(1'b1, f1[1:0], f2[7:0], rd);
        "R": begin
          port_access(1'b0, f1[1:0], 8'h00, rd);
          check_data("dbi", rd, f2[7:0]);
        end
        "P": begin
          cx = f1[10:0];
          cy = f2[9:0];
          @(negedge reset);
        end
        "I": wait_int(f1[0]);
        "M": check_data($sformatf("vram[%05h]", f1[16:0]), vram[f1[16:0]], f2[7:0]);
        "A": check_addr("pram_adr", pram_adr, f1[16:0]);
        default: abort_run($sformatf("Unknown command in vector line: %s", line));
      endcase
    end
    $fclose(fd);

    if (vdp_core_i.checker_i.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/vdp_core_vectors.txt
# W mode byte | R mode expected | P cx cy | I int_n | M addr byte | A addr
# all fields hex; mode 0 is the data port, mode 1 the control/status port
# address 0x0100, data writes on both lanes
W 1 00
W 1 01
W 0 a5
W 0 3c
W 0 7e
W 0 81
M 00100 a5
M 00101 3c
M 00102 7e
M 00103 81
A 00104
# read back from 0x0100
W 1 00
W 1 01
R 0 a5
R 0 3c
R 0 7e
R 0 81
# R14 = 1, address 0x3fff, carry into R14
W 1 01
W 1 8e
W 1 ff
W 1 3f
W 0 11
W 0 22
M 07fff 11
M 08000 22
A 08001
W 1 00
W 1 00
A 08000
W 1 00
W 1 8e
# vblank interrupt through R1 bit 5 and S#0
W 1 20
W 1 81
I 1
P 000 1a8
I 0
P 001 1a8
R 1 80
I 1
R 1 00
# line interrupt through R0 bit 4, R19 = 0x30, S#1
W 1 10
W 1 80
W 1 30
W 1 93
W 1 01
W 1 8f
P 000 060
I 0
P 001 060
R 1 05
I 1
R 1 04
W 1 00
W 1 8f
W 1 00
W 1 80
# latch emptied by a data write, then a fresh R1 write
W 1 00
W 1 81
W 1 81
W 0 99
M 08000 99
W 1 20
W 1 81
P 000 1a8
I 0
P 001 1a8
R 1 80
I 1

//--- src.f
+incdir+design
design/vdp_pkg.sv
design/vdp_port_decode.sv
design/vdp_access_exec.sv
design/vdp_status_result.sv
design/vdp_core.sv
tb/vdp_core_checker.sv
tb/vdp_core_tb.sv

//--- Makefile
# Verilator build and run for vdp_core_tb

.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module vdp_core_tb -o Vvdp_core_tb

run: build
	./obj_dir/Vvdp_core_tb > run.log 2>&1 || true
	@cat run.log
	@if grep -q '\*\* FAIL \*\*' run.log; then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' run.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir run.log
